// File: logic/dc_adc_pkg.sv
package dc_adc_pkg;

    // one conversion result per data line
    localparam int SAMPLE_W = 14;

    // sclk half-period is (clk_div + 1) system clocks
    localparam int DIV_W = 8;

    localparam int FRAME_BITS = 14;                   // rising edges per frame, MSB first
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS);   // indexes 0 .. FRAME_BITS-1

    // reader FSM encoding
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SHIFT = 2'd1;
    localparam logic [1:0] ST_DONE  = 2'd2;

endpackage

// File: logic/dc_regs_pkg.sv
package dc_regs_pkg;

    localparam int ADDR_W   = 4;
    localparam int DATA_W   = 32;
    localparam int PERIOD_W = 16;   // period and threshold registers

    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 4'd0;
    localparam logic [ADDR_W-1:0] ADDR_PERIOD = 4'd1;
    localparam logic [ADDR_W-1:0] ADDR_THRESH = 4'd2;
    localparam logic [ADDR_W-1:0] ADDR_OFFSET = 4'd3;
    localparam logic [ADDR_W-1:0] ADDR_LIMIT  = 4'd4;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'd5;
    localparam logic [ADDR_W-1:0] ADDR_SAMPLE = 4'd6;   // read only

    // field positions inside a register word
    localparam int CTRL_DIV_LSB = 8;
    localparam int PAIR_HI_LSB  = 16;

    // status bits, write 1 to clear
    localparam int STAT_W       = 3;
    localparam int STAT_FAULT_V = 0;
    localparam int STAT_FAULT_I = 1;
    localparam int STAT_OVERRUN = 2;

    typedef struct packed {
        logic [DATA_W-CTRL_DIV_LSB-dc_adc_pkg::DIV_W-1:0] rsvd_hi;
        logic [dc_adc_pkg::DIV_W-1:0]                     clk_div;
        logic [CTRL_DIV_LSB-2:0]                          rsvd_lo;
        logic                                             enable;
    } ctrl_word_t;

    // voltage in the low half, current in the high half
    typedef struct packed {
        logic [DATA_W-PAIR_HI_LSB-dc_adc_pkg::SAMPLE_W-1:0] rsvd_hi;
        logic [dc_adc_pkg::SAMPLE_W-1:0]                    hi;
        logic [PAIR_HI_LSB-dc_adc_pkg::SAMPLE_W-1:0]        rsvd_lo;
        logic [dc_adc_pkg::SAMPLE_W-1:0]                    lo;
    } pair_word_t;

    typedef union packed {
        ctrl_word_t ctrl;
        pair_word_t pair;
    } reg_word_u;

endpackage

// File: logic/dc_reg_decode.sv
module dc_reg_decode (
    input  logic                              dc_clk,
    input  logic                              i_rst_n,
    input  logic                              i_wr_en,
    input  logic                              i_rd_en,
    input  logic [dc_regs_pkg::ADDR_W-1:0]    i_addr,
    input  logic [dc_regs_pkg::DATA_W-1:0]    i_wdata,
    input  logic [dc_adc_pkg::SAMPLE_W-1:0]   i_dc_v,
    input  logic [dc_adc_pkg::SAMPLE_W-1:0]   i_dc_i,
    input  logic [dc_regs_pkg::STAT_W-1:0]    i_status,
    output logic                              o_enable,
    output logic [dc_adc_pkg::DIV_W-1:0]      o_clk_div,
    output logic [dc_regs_pkg::PERIOD_W-1:0]  o_period,
    output logic [dc_regs_pkg::PERIOD_W-1:0]  o_thresh,
    output logic [dc_adc_pkg::SAMPLE_W-1:0]   o_offset_v,
    output logic [dc_adc_pkg::SAMPLE_W-1:0]   o_offset_i,
    output logic [dc_adc_pkg::SAMPLE_W-1:0]   o_limit_v,
    output logic [dc_adc_pkg::SAMPLE_W-1:0]   o_limit_i,
    output logic [dc_regs_pkg::STAT_W-1:0]    o_clear,
    output logic [dc_regs_pkg::DATA_W-1:0]    o_rdata
);
    import dc_regs_pkg::*;

    reg_word_u wword;
    reg_word_u rword;

    assign wword = i_wdata;

    always_ff @(posedge dc_clk) begin
        if (!i_rst_n) begin
            o_enable   <= 1'b0;
            o_clk_div  <= '0;
            o_period   <= '0;
            o_thresh   <= '0;
            o_offset_v <= '0;
            o_offset_i <= '0;
            o_limit_v  <= '0;
            o_limit_i  <= '0;
            o_clear    <= '0;
        end else begin
            o_clear <= '0;  // clear mask lives for one cycle only
            if (i_wr_en) begin
                case (i_addr)
                    ADDR_CTRL: begin
                        o_enable  <= wword.ctrl.enable;
                        o_clk_div <= wword.ctrl.clk_div;
                    end
                    ADDR_PERIOD: o_period <= i_wdata[PERIOD_W-1:0];
                    ADDR_THRESH: o_thresh <= i_wdata[PERIOD_W-1:0];
                    ADDR_OFFSET: begin
                        o_offset_v <= wword.pair.lo;
                        o_offset_i <= wword.pair.hi;
                    end
                    ADDR_LIMIT: begin
                        o_limit_v <= wword.pair.lo;
                        o_limit_i <= wword.pair.hi;
                    end
                    ADDR_STATUS: o_clear <= i_wdata[STAT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // read word is assembled through the same union views as the write path
    always_comb begin
        rword = '0;
        case (i_addr)
            ADDR_CTRL: begin
                rword.ctrl.enable  = o_enable;
                rword.ctrl.clk_div = o_clk_div;
            end
            ADDR_PERIOD: rword[PERIOD_W-1:0] = o_period;
            ADDR_THRESH: rword[PERIOD_W-1:0] = o_thresh;
            ADDR_OFFSET: begin
                rword.pair.lo = o_offset_v;
                rword.pair.hi = o_offset_i;
            end
            ADDR_LIMIT: begin
                rword.pair.lo = o_limit_v;
                rword.pair.hi = o_limit_i;
            end
            ADDR_STATUS: rword[STAT_W-1:0] = i_status;
            ADDR_SAMPLE: begin
                rword.pair.lo = i_dc_v;
                rword.pair.hi = i_dc_i;
            end
            default: rword = '0;    // unmapped reads as zero
        endcase
    end

    always_ff @(posedge dc_clk) begin
        if (!i_rst_n) begin
            o_rdata <= '0;
        end else if (i_rd_en) begin
            o_rdata <= rword;   // held until the next read
        end
    end

    a_no_rd_wr_overlap: assert property (@(posedge dc_clk) disable iff (!i_rst_n)
        !(i_wr_en && i_rd_en));

endmodule

// File: logic/dc_sample_timer.sv
module dc_sample_timer (
    input  logic                              dc_clk,
    input  logic                              i_rst_n,
    input  logic                              i_enable,
    input  logic [dc_regs_pkg::PERIOD_W-1:0]  i_period,
    input  logic [dc_regs_pkg::PERIOD_W-1:0]  i_thresh,
    output logic                              o_trigger
);
    import dc_regs_pkg::*;

    logic [PERIOD_W-1:0] cnt;
    logic [PERIOD_W:0]   cnt_inc;   // one bit wider so the wrap test cannot overflow

    assign cnt_inc = {1'b0, cnt} + 1'b1;

    always_ff @(posedge dc_clk) begin
        if (!i_rst_n) begin
            cnt <= '0;
        end else if (!i_enable) begin
            cnt <= '0;
        end else if (cnt_inc >= {1'b0, i_period}) begin
            cnt <= '0;  // last count of the period
        end else begin
            cnt <= cnt_inc[PERIOD_W-1:0];
        end
    end

    // exactly one match per pass through the period
    assign o_trigger = i_enable && (cnt == i_thresh);

endmodule

// File: logic/dc_adc_reader.sv
module dc_adc_reader (
    input  logic                             dc_clk,
    input  logic                             i_rst_n,
    input  logic                             i_trigger,
    input  logic [dc_adc_pkg::DIV_W-1:0]     i_clk_div,
    input  logic                             i_miso_v,
    input  logic                             i_miso_i,
    output logic                             o_spi_sclk,
    output logic                             o_spi_cs_n,
    output logic                             o_valid,
    output logic [dc_adc_pkg::SAMPLE_W-1:0]  o_raw_v,
    output logic [dc_adc_pkg::SAMPLE_W-1:0]  o_raw_i,
    output logic                             o_overrun
);
    import dc_adc_pkg::*;

    logic [1:0]           state;
    logic [DIV_W-1:0]     div_q;    // divider captured at trigger for the whole frame
    logic [DIV_W-1:0]     div_cnt;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [SAMPLE_W-1:0]  shift_v;
    logic [SAMPLE_W-1:0]  shift_i;

    always_ff @(posedge dc_clk) begin
        if (!i_rst_n) begin
            state      <= ST_IDLE;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            o_spi_sclk <= 1'b0;
            o_spi_cs_n <= 1'b1;
            o_valid    <= 1'b0;
            o_overrun  <= 1'b0;
        end else begin
            o_valid   <= 1'b0;
            o_overrun <= i_trigger && (state != ST_IDLE);   // busy, this trigger is lost
            case (state)
                ST_IDLE: begin
                    if (i_trigger) begin
                        state      <= ST_SHIFT;
                        o_spi_cs_n <= 1'b0;
                        div_cnt    <= '0;
                        bit_cnt    <= '0;
                    end
                end
                ST_SHIFT: begin
                    if (div_cnt == div_q) begin
                        div_cnt    <= '0;
                        o_spi_sclk <= ~o_spi_sclk;
                        if (o_spi_sclk) begin
                            // falling edge, the ADC has held this bit since the rise
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
                                state <= ST_DONE;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                ST_DONE: begin
                    o_spi_cs_n <= 1'b1;
                    o_valid    <= 1'b1;
                    state      <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload path, sampled on each sclk fall
    always_ff @(posedge dc_clk) begin
        if (state == ST_IDLE && i_trigger) begin
            div_q <= i_clk_div;
        end
        if (state == ST_SHIFT && div_cnt == div_q && o_spi_sclk) begin
            shift_v <= {shift_v[SAMPLE_W-2:0], i_miso_v};
            shift_i <= {shift_i[SAMPLE_W-2:0], i_miso_i};
        end
    end

    assign o_raw_v = shift_v;
    assign o_raw_i = shift_i;

    a_sclk_idle_low: assert property (@(posedge dc_clk) disable iff (!i_rst_n)
        o_spi_cs_n |-> !o_spi_sclk);

    a_valid_after_frame: assert property (@(posedge dc_clk) disable iff (!i_rst_n)
        o_valid |-> o_spi_cs_n);

endmodule

// File: logic/dc_link_monitor.sv
module dc_link_monitor (
    input  logic                             dc_clk,
    input  logic                             i_rst_n,
    input  logic                             i_valid,
    input  logic [dc_adc_pkg::SAMPLE_W-1:0]  i_raw_v,
    input  logic [dc_adc_pkg::SAMPLE_W-1:0]  i_raw_i,
    input  logic [dc_adc_pkg::SAMPLE_W-1:0]  i_offset_v,
    input  logic [dc_adc_pkg::SAMPLE_W-1:0]  i_offset_i,
    input  logic [dc_adc_pkg::SAMPLE_W-1:0]  i_limit_v,
    input  logic [dc_adc_pkg::SAMPLE_W-1:0]  i_limit_i,
    input  logic                             i_overrun,
    input  logic [dc_regs_pkg::STAT_W-1:0]   i_clear,
    output logic                             o_sample_valid,
    output logic [dc_adc_pkg::SAMPLE_W-1:0]  o_dc_v,
    output logic [dc_adc_pkg::SAMPLE_W-1:0]  o_dc_i,
    output logic [dc_regs_pkg::STAT_W-1:0]   o_status,
    output logic                             o_fault
);
    import dc_adc_pkg::*;
    import dc_regs_pkg::*;

    logic [SAMPLE_W:0]   diff_v;    // top bit is the borrow
    logic [SAMPLE_W:0]   diff_i;
    logic [SAMPLE_W-1:0] corr_v;
    logic [SAMPLE_W-1:0] corr_i;
    logic                over_v;
    logic                over_i;

    assign diff_v = {1'b0, i_raw_v} - {1'b0, i_offset_v};
    assign diff_i = {1'b0, i_raw_i} - {1'b0, i_offset_i};

    // negative results clamp to zero
    assign corr_v = diff_v[SAMPLE_W] ? '0 : diff_v[SAMPLE_W-1:0];
    assign corr_i = diff_i[SAMPLE_W] ? '0 : diff_i[SAMPLE_W-1:0];

    assign over_v = i_valid && (corr_v > i_limit_v);
    assign over_i = i_valid && (corr_i > i_limit_i);

    always_ff @(posedge dc_clk) begin
        if (!i_rst_n) begin
            o_sample_valid <= 1'b0;
            o_dc_v         <= '0;
            o_dc_i         <= '0;
            o_status       <= '0;
        end else begin
            o_sample_valid <= i_valid;
            if (i_valid) begin
                o_dc_v <= corr_v;
                o_dc_i <= corr_i;
            end
            // a new event in the same cycle as its clear keeps the flag set
            o_status[STAT_FAULT_V] <= (o_status[STAT_FAULT_V] & ~i_clear[STAT_FAULT_V]) | over_v;
            o_status[STAT_FAULT_I] <= (o_status[STAT_FAULT_I] & ~i_clear[STAT_FAULT_I]) | over_i;
            o_status[STAT_OVERRUN] <= (o_status[STAT_OVERRUN] & ~i_clear[STAT_OVERRUN])
                                      | i_overrun;
        end
    end

    assign o_fault = o_status[STAT_FAULT_V] | o_status[STAT_FAULT_I];

    a_fault_v_sticky: assert property (@(posedge dc_clk) disable iff (!i_rst_n)
        $fell(o_status[STAT_FAULT_V]) |-> $past(i_clear[STAT_FAULT_V]));

    a_fault_i_sticky: assert property (@(posedge dc_clk) disable iff (!i_rst_n)
        $fell(o_status[STAT_FAULT_I]) |-> $past(i_clear[STAT_FAULT_I]));

endmodule

// File: logic/dc_sense_top.sv
module dc_sense_top (
    input  logic                             dc_clk,
    input  logic                             i_rst_n,
    input  logic                             i_wr_en,
    input  logic                             i_rd_en,
    input  logic [dc_regs_pkg::ADDR_W-1:0]   i_addr,
    input  logic [dc_regs_pkg::DATA_W-1:0]   i_wdata,
    input  logic                             i_spi_miso_v,
    input  logic                             i_spi_miso_i,
    output logic [dc_regs_pkg::DATA_W-1:0]   o_rdata,
    output logic                             o_spi_sclk,
    output logic                             o_spi_cs_n,
    output logic                             o_sample_valid,
    output logic [dc_adc_pkg::SAMPLE_W-1:0]  o_dc_v,
    output logic [dc_adc_pkg::SAMPLE_W-1:0]  o_dc_i,
    output logic                             o_fault
);
    import dc_adc_pkg::*;
    import dc_regs_pkg::*;

    logic                enable;
    logic [DIV_W-1:0]    clk_div;
    logic [PERIOD_W-1:0] period;
    logic [PERIOD_W-1:0] thresh;
    logic [SAMPLE_W-1:0] offset_v;
    logic [SAMPLE_W-1:0] offset_i;
    logic [SAMPLE_W-1:0] limit_v;
    logic [SAMPLE_W-1:0] limit_i;
    logic [STAT_W-1:0]   clear;
    logic [STAT_W-1:0]   status;
    logic                trigger;
    logic                raw_valid;
    logic [SAMPLE_W-1:0] raw_v;
    logic [SAMPLE_W-1:0] raw_i;
    logic                overrun;

    dc_reg_decode u_decode (
        .dc_clk     (dc_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_en    (i_wr_en),
        .i_rd_en    (i_rd_en),
        .i_addr     (i_addr),
        .i_wdata    (i_wdata),
        .i_dc_v     (o_dc_v),
        .i_dc_i     (o_dc_i),
        .i_status   (status),
        .o_enable   (enable),
        .o_clk_div  (clk_div),
        .o_period   (period),
        .o_thresh   (thresh),
        .o_offset_v (offset_v),
        .o_offset_i (offset_i),
        .o_limit_v  (limit_v),
        .o_limit_i  (limit_i),
        .o_clear    (clear),
        .o_rdata    (o_rdata)
    );

    dc_sample_timer u_timer (
        .dc_clk    (dc_clk),
        .i_rst_n   (i_rst_n),
        .i_enable  (enable),
        .i_period  (period),
        .i_thresh  (thresh),
        .o_trigger (trigger)
    );

    dc_adc_reader u_reader (
        .dc_clk     (dc_clk),
        .i_rst_n    (i_rst_n),
        .i_trigger  (trigger),
        .i_clk_div  (clk_div),
        .i_miso_v   (i_spi_miso_v),
        .i_miso_i   (i_spi_miso_i),
        .o_spi_sclk (o_spi_sclk),
        .o_spi_cs_n (o_spi_cs_n),
        .o_valid    (raw_valid),
        .o_raw_v    (raw_v),
        .o_raw_i    (raw_i),
        .o_overrun  (overrun)
    );

    dc_link_monitor u_monitor (
        .dc_clk         (dc_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (raw_valid),
        .i_raw_v        (raw_v),
        .i_raw_i        (raw_i),
        .i_offset_v     (offset_v),
        .i_offset_i     (offset_i),
        .i_limit_v      (limit_v),
        .i_limit_i      (limit_i),
        .i_overrun      (overrun),
        .i_clear        (clear),
        .o_sample_valid (o_sample_valid),
        .o_dc_v         (o_dc_v),
        .o_dc_i         (o_dc_i),
        .o_status       (status),
        .o_fault        (o_fault)
    );

endmodule

// File: tb/dc_adc_model.sv
module dc_adc_model (
    input  logic                            i_sclk,
    input  logic                            i_cs_n,
    input  logic [dc_adc_pkg::SAMPLE_W-1:0] i_code_v,
    input  logic [dc_adc_pkg::SAMPLE_W-1:0] i_code_i,
    output logic                            o_miso_v,
    output logic                            o_miso_i
);
    timeunit 1ns;
    timeprecision 100ps;

    import dc_adc_pkg::*;

    localparam int DRIVE_DELAY = 2;

    logic [SAMPLE_W-1:0] frame_v;
    logic [SAMPLE_W-1:0] frame_i;

    initial begin
        o_miso_v = 1'b0;
        o_miso_i = 1'b0;
    end

    // one frame per falling chip select, codes are frozen for the whole frame
    always begin
        @(negedge i_cs_n);
        frame_v = i_code_v;
        frame_i = i_code_i;
        for (int b = 0; b < FRAME_BITS; b++) begin
            @(posedge i_sclk);
            #DRIVE_DELAY;   // data moves just after the rising edge, MSB first
            o_miso_v = frame_v[SAMPLE_W-1-b];
            o_miso_i = frame_i[SAMPLE_W-1-b];
        end
    end

endmodule

// File: tb/dc_sense_tb.sv
module dc_sense_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import dc_adc_pkg::*;
    import dc_regs_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int DRIVE_DELAY    = 2;
    localparam int SAMPLE_PERIOD  = 200;   // well above the 58 clock conversion at div 1
    localparam int SAMPLE_THRESH  = 10;
    localparam int SAMPLE_WAIT    = 2 * SAMPLE_PERIOD;
    localparam int NUM_SAMPLES    = 6;
    localparam int RATE_N         = 5;
    localparam int OVERRUN_PERIOD = 40;

    localparam logic [DIV_W-1:0]    TEST_DIV = 8'd1;
    localparam logic [SAMPLE_W-1:0] OFF_V    = 14'd900;
    localparam logic [SAMPLE_W-1:0] OFF_I    = 14'd300;
    localparam logic [SAMPLE_W-1:0] LIM_V    = 14'd1000;
    localparam logic [SAMPLE_W-1:0] LIM_I    = 14'd500;
    localparam logic [SAMPLE_W-1:0] LIM_MAX  = '1;

    // per-test cycle budgets that the watchdog adds up
    localparam int BUDGET_RESET   = RESET_CYCLES + 20;
    localparam int BUDGET_REGS    = 40;
    localparam int BUDGET_SAMPLES = NUM_SAMPLES * (SAMPLE_WAIT + 4) + 20;
    localparam int BUDGET_FAULT   = 3 * SAMPLE_WAIT + 40;
    localparam int BUDGET_RATE    = RATE_N * SAMPLE_PERIOD + 20;
    localparam int BUDGET_OVERRUN = 3 * SAMPLE_WAIT + 20;
    localparam int BUDGET_TOTAL   = BUDGET_RESET + BUDGET_REGS + BUDGET_SAMPLES
                                    + BUDGET_FAULT + BUDGET_RATE + BUDGET_OVERRUN;

    logic                dc_clk;
    logic                rst_n;
    logic                wr_en;
    logic                rd_en;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W-1:0]   rdata;
    logic                spi_sclk;
    logic                spi_cs_n;
    logic                spi_miso_v;
    logic                spi_miso_i;
    logic                sample_valid;
    logic [SAMPLE_W-1:0] dc_v;
    logic [SAMPLE_W-1:0] dc_i;
    logic                fault;
    logic [SAMPLE_W-1:0] code_v;
    logic [SAMPLE_W-1:0] code_i;
    int                  seed = 32'hddef;

    dc_sense_top dut (
        .dc_clk         (dc_clk),
        .i_rst_n        (rst_n),
        .i_wr_en        (wr_en),
        .i_rd_en        (rd_en),
        .i_addr         (addr),
        .i_wdata        (wdata),
        .i_spi_miso_v   (spi_miso_v),
        .i_spi_miso_i   (spi_miso_i),
        .o_rdata        (rdata),
        .o_spi_sclk     (spi_sclk),
        .o_spi_cs_n     (spi_cs_n),
        .o_sample_valid (sample_valid),
        .o_dc_v         (dc_v),
        .o_dc_i         (dc_i),
        .o_fault        (fault)
    );

    dc_adc_model u_adc (
        .i_sclk   (spi_sclk),
        .i_cs_n   (spi_cs_n),
        .i_code_v (code_v),
        .i_code_i (code_i),
        .o_miso_v (spi_miso_v),
        .o_miso_i (spi_miso_i)
    );

    initial dc_clk = 1'b0;
    always #(CLK_PERIOD / 2) dc_clk = ~dc_clk;

    task automatic stop_on_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected 0x%h, actual 0x%h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    function automatic logic [DATA_W-1:0] ctrl_word(input logic en, input logic [DIV_W-1:0] div);
        reg_word_u w;
        w = '0;
        w.ctrl.enable  = en;
        w.ctrl.clk_div = div;
        return w;
    endfunction

    function automatic logic [DATA_W-1:0] pair_word(input logic [SAMPLE_W-1:0] lo,
                                                    input logic [SAMPLE_W-1:0] hi);
        reg_word_u w;
        w = '0;
        w.pair.lo = lo;
        w.pair.hi = hi;
        return w;
    endfunction

    // offset removal with the result floored at zero
    function automatic logic [SAMPLE_W-1:0] clamp_sub(input logic [SAMPLE_W-1:0] raw,
                                                      input logic [SAMPLE_W-1:0] off);
        if (raw > off) begin
            return raw - off;
        end
        return '0;
    endfunction

    // all tasks start and end just after a rising edge
    task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        addr  = a;
        wdata = d;
        wr_en = 1'b1;
        @(posedge dc_clk);
        #DRIVE_DELAY;
        wr_en = 1'b0;
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
        addr  = a;
        rd_en = 1'b1;
        @(posedge dc_clk);
        #DRIVE_DELAY;
        rd_en = 1'b0;
        d     = rdata;
    endtask

    task automatic wait_sample(input int budget);
        int n;
        n = 0;
        do begin
            @(posedge dc_clk);
            #DRIVE_DELAY;
            n++;
            if (n > budget) begin
                $display("no sample arrived within %0d cycles", budget);
                stop_on_failure();
            end
        end while (!sample_valid);
    endtask

    task automatic after_reset();
        logic [DATA_W-1:0] rd;
        check_value("after_reset cs_n", 1, spi_cs_n);
        check_value("after_reset sclk", 0, spi_sclk);
        check_value("after_reset sample_valid", 0, sample_valid);
        check_value("after_reset fault", 0, fault);
        read_reg(ADDR_CTRL, rd);
        check_value("after_reset CTRL", 0, rd);
        read_reg(ADDR_STATUS, rd);
        check_value("after_reset STATUS", 0, rd);
        read_reg(ADDR_SAMPLE, rd);
        check_value("after_reset SAMPLE", 0, rd);
    endtask

    task automatic register_readback();
        logic [ADDR_W-1:0] addrs[5];
        logic [DATA_W-1:0] words[5];
        logic [DATA_W-1:0] rd;
        addrs = '{ADDR_CTRL, ADDR_PERIOD, ADDR_THRESH, ADDR_OFFSET, ADDR_LIMIT};
        words[0] = ctrl_word(1'b0, 8'h5a);  // stays disabled
        words[1] = 32'h0000_1234;
        words[2] = 32'h0000_0abc;
        words[3] = pair_word(14'h1555, 14'h2aaa);
        words[4] = pair_word(14'h0f0f, 14'h30c3);
        foreach (addrs[k]) begin
            write_reg(addrs[k], words[k]);
        end
        foreach (addrs[k]) begin
            read_reg(addrs[k], rd);
            check_value($sformatf("register_readback addr %0d", addrs[k]), words[k], rd);
        end
    endtask

    task automatic corrected_samples();
        logic [DATA_W-1:0]   rd;
        logic [SAMPLE_W-1:0] exp_v;
        logic [SAMPLE_W-1:0] exp_i;
        int                  r;
        write_reg(ADDR_OFFSET, pair_word(OFF_V, OFF_I));
        write_reg(ADDR_LIMIT, pair_word(LIM_MAX, LIM_MAX));
        write_reg(ADDR_PERIOD, SAMPLE_PERIOD);
        write_reg(ADDR_THRESH, SAMPLE_THRESH);
        write_reg(ADDR_CTRL, ctrl_word(1'b1, TEST_DIV));
        for (int k = 0; k < NUM_SAMPLES; k++) begin
            r = $random(seed);
            code_v = r[SAMPLE_W-1:0];
            r = $random(seed);
            code_i = r[SAMPLE_W-1:0];
            if (k % 3 == 1) code_v = code_v % OFF_V;    // these codes sit below the offset
            if (k % 3 == 2) code_i = code_i % OFF_I;
            exp_v = clamp_sub(code_v, OFF_V);
            exp_i = clamp_sub(code_i, OFF_I);
            wait_sample(SAMPLE_WAIT);
            check_value("corrected_samples dc_v", exp_v, dc_v);
            check_value("corrected_samples dc_i", exp_i, dc_i);
            read_reg(ADDR_SAMPLE, rd);
            check_value("corrected_samples SAMPLE", pair_word(exp_v, exp_i), rd);
        end
    endtask

    task automatic fault_and_clear();
        logic [DATA_W-1:0] rd;
        write_reg(ADDR_LIMIT, pair_word(LIM_V, LIM_I));
        code_v = OFF_V + 14'd1500;  // only the voltage leaves its limit
        code_i = OFF_I + 14'd10;
        wait_sample(SAMPLE_WAIT);
        check_value("fault_and_clear fault set", 1, fault);
        code_v = OFF_V + 14'd10;
        code_i = OFF_I + 14'd800;
        read_reg(ADDR_STATUS, rd);
        check_value("fault_and_clear STATUS voltage", 32'h1, rd);
        wait_sample(SAMPLE_WAIT);
        code_v = OFF_V + 14'd10;    // next frame stays inside both limits
        code_i = OFF_I + 14'd10;
        read_reg(ADDR_STATUS, rd);
        check_value("fault_and_clear STATUS both", 32'h3, rd);
        write_reg(ADDR_STATUS, 32'h1);
        @(posedge dc_clk);
        #DRIVE_DELAY;
        check_value("fault_and_clear fault_i holds", 1, fault);
        read_reg(ADDR_STATUS, rd);
        check_value("fault_and_clear STATUS current", 32'h2, rd);
        write_reg(ADDR_STATUS, 32'h2);
        @(posedge dc_clk);
        #DRIVE_DELAY;
        check_value("fault_and_clear fault cleared", 0, fault);
        read_reg(ADDR_STATUS, rd);
        check_value("fault_and_clear STATUS clear", 0, rd);
        wait_sample(SAMPLE_WAIT);
        check_value("fault_and_clear no new fault", 0, fault);
        write_reg(ADDR_LIMIT, pair_word(LIM_MAX, LIM_MAX));
    endtask

    task automatic sample_rate();
        int count;
        count = 0;
        repeat (RATE_N * SAMPLE_PERIOD) begin
            @(posedge dc_clk);
            #DRIVE_DELAY;
            if (sample_valid) count++;
        end
        check_value("sample_rate count within one of N", 1,
                    (count >= RATE_N - 1) && (count <= RATE_N + 1));
    endtask

    task automatic overrun_flag();
        logic [DATA_W-1:0] rd;
        read_reg(ADDR_STATUS, rd);
        check_value("overrun_flag STATUS before", 0, rd);
        write_reg(ADDR_THRESH, 0);
        write_reg(ADDR_PERIOD, OVERRUN_PERIOD);   // shorter than one conversion
        wait_sample(SAMPLE_WAIT);
        wait_sample(SAMPLE_WAIT);
        read_reg(ADDR_STATUS, rd);
        check_value("overrun_flag STATUS overrun", 1, rd[STAT_OVERRUN]);
        wait_sample(SAMPLE_WAIT);
        write_reg(ADDR_CTRL, ctrl_word(1'b0, TEST_DIV));
    endtask

    initial begin
        #(BUDGET_TOTAL * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        stop_on_failure();
    end

    initial begin
        rst_n  = 1'b0;
        wr_en  = 1'b0;
        rd_en  = 1'b0;
        addr   = '0;
        wdata  = '0;
        code_v = '0;
        code_i = '0;
        repeat (RESET_CYCLES) @(posedge dc_clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        after_reset();
        register_readback();
        corrected_samples();
        fault_and_clear();
        sample_rate();
        overrun_flag();
        $display("test passed");
        $finish;
    end

endmodule

// File: filelist.f
logic/dc_adc_pkg.sv
logic/dc_regs_pkg.sv
logic/dc_reg_decode.sv
logic/dc_sample_timer.sv
logic/dc_adc_reader.sv
logic/dc_link_monitor.sv
logic/dc_sense_top.sv
tb/dc_adc_model.sv
tb/dc_sense_tb.sv
